//--- design/exc_pkg.sv
package exc_pkg;

    // ==============================
    // Exception codes
    // ==============================
    localparam logic [4:0] EXC_INT  = 5'd0;
    localparam logic [4:0] EXC_ADEL = 5'd4;   // Load or fetch address error.
    localparam logic [4:0] EXC_ADES = 5'd5;   // Store address error.
    localparam logic [4:0] EXC_SYS  = 5'd8;
    localparam logic [4:0] EXC_BP   = 5'd9;
    localparam logic [4:0] EXC_RI   = 5'd10;  // Reserved instruction.
    localparam logic [4:0] EXC_OV   = 5'd12;
    localparam logic [4:0] EXC_TR   = 5'd13;

    // ==============================
    // Vectors
    // ==============================
    localparam logic [31:0] EBASE      = 32'hBFC0_0200;  // Boot exception base, BEV=1.
    localparam logic [31:0] EXC_VECTOR = EBASE + 32'h0000_0180;

    // ==============================
    // CP0 register numbers
    // ==============================
    localparam logic [4:0] CP0_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_STATUS   = 5'd12;
    localparam logic [4:0] CP0_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_EPC      = 5'd14;

    // Status fields.
    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_IM_LO = 8;  // IM7..IM0 occupy bits 15:8.

    // Cause fields.
    localparam int CAUSE_EXC_LO = 2;  // ExcCode occupies bits 6:2.
    localparam int CAUSE_IP_LO  = 8;  // IP1..IP0 software, IP7..IP2 hardware.
    localparam int CAUSE_BD     = 31;

    // Out of reset the core sits at exception level with interrupts masked.
    localparam logic [31:0] STATUS_RESET = 32'h0000_0002;

endpackage

//--- design/exception_unit.sv
`timescale 1ns/1ps

module exception_unit (
    input  logic        clk,
    input  logic        reset,

    input  logic [31:0] pc,
    input  logic [31:0] data_vaddr,
    input  logic        data_we,
    input  logic        in_delayslot,

    input  logic        illegal_inst,
    input  logic        illegal_data,
    input  logic        syscall,
    input  logic        brk,
    input  logic        trap,
    input  logic        unknown_inst,
    input  logic        overflow,
    input  logic        eret,

    input  logic        int_pending,
    input  logic [31:0] epc_out,

    input  logic        inst_data_ok,
    input  logic        icache_stall,
    input  logic        inst_uncached,

    output logic        current_exception,
    output logic        flush,
    output logic [31:0] new_pc,

    output logic        exc_we,
    output logic [4:0]  exc_code,
    output logic [31:0] exc_epc,
    output logic        exc_bd,
    output logic        badvaddr_we,
    output logic [31:0] badvaddr,
    output logic        eret_commit
);

    import exc_pkg::*;

    logic        take_exc;
    logic        take_ret;
    logic [4:0]  nxt_code;
    logic        nxt_bv_we;
    logic [31:0] nxt_bv;
    logic [31:0] nxt_epc;
    logic        fetch_ready;

    assign current_exception = int_pending | illegal_inst | illegal_data | syscall | brk |
                               trap | unknown_inst | overflow | eret;

    // Restart at the branch when the faulting instruction sits in a delay slot.
    assign nxt_epc = in_delayslot ? pc - 32'd4 : pc;

    assign fetch_ready = inst_data_ok | (!icache_stall & !inst_uncached);

    // ==============================
    // Priority select
    // ==============================
    always_comb begin
        take_exc  = 1'b1;
        nxt_code  = EXC_INT;
        nxt_bv_we = 1'b0;
        nxt_bv    = pc;
        if (int_pending) begin
            nxt_code = EXC_INT;
        end else if (illegal_inst) begin
            nxt_code  = EXC_ADEL;  // Misaligned fetch.
            nxt_bv_we = 1'b1;
            nxt_bv    = pc;
        end else if (illegal_data) begin
            nxt_code  = data_we ? EXC_ADES : EXC_ADEL;
            nxt_bv_we = 1'b1;
            nxt_bv    = data_vaddr;
        end else if (syscall) begin
            nxt_code = EXC_SYS;
        end else if (brk) begin
            nxt_code = EXC_BP;
        end else if (trap) begin
            nxt_code = EXC_TR;
        end else if (unknown_inst) begin
            nxt_code = EXC_RI;
        end else if (overflow) begin
            nxt_code = EXC_OV;
        end else begin
            take_exc = 1'b0;
        end
    end

    assign take_ret = eret & !take_exc;  // Any real exception outranks eret.

    // ==============================
    // Registered redirect and strobes
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            flush       <= 1'b0;
            new_pc      <= 32'd0;
            exc_we      <= 1'b0;
            exc_code    <= 5'd0;
            badvaddr_we <= 1'b0;
            eret_commit <= 1'b0;
        end else begin
            exc_we      <= take_exc;
            badvaddr_we <= take_exc & nxt_bv_we;
            eret_commit <= take_ret;
            exc_code    <= take_exc ? nxt_code : 5'd0;

            if (take_exc) begin
                new_pc <= EXC_VECTOR;
            end else if (take_ret) begin
                new_pc <= epc_out;
            end

            // Flush holds until fetch can accept the redirect.
            if (take_exc | take_ret) begin
                flush <= 1'b1;
            end else if (fetch_ready) begin
                flush <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_exc) begin
            exc_epc  <= nxt_epc;
            exc_bd   <= in_delayslot;
            badvaddr <= nxt_bv;
        end
    end

    // ==============================
    // Checks
    // ==============================
    a_we_ret_excl: assert property (@(posedge clk) disable iff (reset)
        !(exc_we && eret_commit));

    a_bv_needs_we: assert property (@(posedge clk) disable iff (reset)
        badvaddr_we |-> exc_we);

endmodule

//--- design/cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs (
    input  logic        clk,
    input  logic        reset,

    input  logic        cp0_we,
    input  logic [4:0]  cp0_addr,
    input  logic [31:0] cp0_wdata,
    output logic [31:0] cp0_rdata,

    input  logic [5:0]  hw_int,

    input  logic        exc_we,
    input  logic [4:0]  exc_code,
    input  logic [31:0] exc_epc,
    input  logic        exc_bd,
    input  logic        badvaddr_we,
    input  logic [31:0] badvaddr,
    input  logic        eret_commit,

    output logic        int_pending,
    output logic [31:0] epc_out
);

    import exc_pkg::*;

    // Status fields.
    logic        status_ie;
    logic        status_exl;
    logic [7:0]  status_im;

    // Cause fields.
    logic        cause_bd;
    logic [5:0]  cause_ip_hw;
    logic [1:0]  cause_ip_sw;
    logic [4:0]  cause_exc;

    logic [31:0] epc_r;
    logic [31:0] badvaddr_r;

    logic [31:0] status_word;
    logic [31:0] cause_word;
    logic [7:0]  ip_live;

    logic        wr_status;
    logic        wr_cause;
    logic        wr_epc;
    logic        wr_badvaddr;

    // Software writes lose to a same-cycle event on the same register.
    assign wr_status   = cp0_we && cp0_addr == CP0_STATUS && !exc_we && !eret_commit;
    assign wr_cause    = cp0_we && cp0_addr == CP0_CAUSE && !exc_we;
    assign wr_epc      = cp0_we && cp0_addr == CP0_EPC && !exc_we;
    assign wr_badvaddr = cp0_we && cp0_addr == CP0_BADVADDR && !badvaddr_we;

    // ==============================
    // Status
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            status_ie  <= STATUS_RESET[STATUS_IE];
            status_exl <= STATUS_RESET[STATUS_EXL];
            status_im  <= STATUS_RESET[STATUS_IM_LO +: 8];
        end else if (exc_we) begin
            status_exl <= 1'b1;
        end else if (eret_commit) begin
            status_exl <= 1'b0;
        end else if (wr_status) begin
            status_ie  <= cp0_wdata[STATUS_IE];
            status_exl <= cp0_wdata[STATUS_EXL];
            status_im  <= cp0_wdata[STATUS_IM_LO +: 8];
        end
    end

    // ==============================
    // Cause
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd    <= 1'b0;
            cause_ip_hw <= 6'd0;
            cause_ip_sw <= 2'd0;
            cause_exc   <= 5'd0;
        end else begin
            cause_ip_hw <= hw_int;  // Hardware lines are sampled every cycle.
            if (exc_we) begin
                cause_bd  <= exc_bd;
                cause_exc <= exc_code;
            end else if (wr_cause) begin
                cause_ip_sw <= cp0_wdata[CAUSE_IP_LO +: 2];
            end
        end
    end

    // ==============================
    // EPC and BadVAddr
    // ==============================
    always_ff @(posedge clk) begin
        if (exc_we) begin
            epc_r <= exc_epc;
        end else if (wr_epc) begin
            epc_r <= cp0_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (badvaddr_we) begin
            badvaddr_r <= badvaddr;
        end else if (wr_badvaddr) begin
            badvaddr_r <= cp0_wdata;
        end
    end

    // Register images as software sees them.
    always_comb begin
        status_word                       = 32'd0;
        status_word[STATUS_IE]            = status_ie;
        status_word[STATUS_EXL]           = status_exl;
        status_word[STATUS_IM_LO +: 8]    = status_im;

        cause_word                        = 32'd0;
        cause_word[CAUSE_BD]              = cause_bd;
        cause_word[CAUSE_IP_LO +: 2]      = cause_ip_sw;
        cause_word[CAUSE_IP_LO + 2 +: 6]  = cause_ip_hw;
        cause_word[CAUSE_EXC_LO +: 5]     = cause_exc;
    end

    always_comb begin
        case (cp0_addr)
            CP0_STATUS:   cp0_rdata = status_word;
            CP0_CAUSE:    cp0_rdata = cause_word;
            CP0_EPC:      cp0_rdata = epc_r;
            CP0_BADVADDR: cp0_rdata = badvaddr_r;
            default:      cp0_rdata = 32'd0;
        endcase
    end

    // Live hw lines so an interrupt is seen in the cycle it rises.
    assign ip_live     = {hw_int, cause_ip_sw};
    assign int_pending = status_ie && !status_exl && |(ip_live & status_im);

    assign epc_out = epc_r;

    // ==============================
    // Checks
    // ==============================
    a_no_exc_and_ret: assert property (@(posedge clk) disable iff (reset)
        !(exc_we && eret_commit));

endmodule

//--- design/exc_top.sv
`timescale 1ns/1ps

module exc_top (
    input  logic        clk,
    input  logic        reset,

    // Execute stage.
    input  logic [31:0] pc,
    input  logic [31:0] data_vaddr,
    input  logic        data_we,
    input  logic        in_delayslot,
    input  logic        illegal_inst,
    input  logic        illegal_data,
    input  logic        syscall,
    input  logic        brk,
    input  logic        trap,
    input  logic        unknown_inst,
    input  logic        overflow,
    input  logic        eret,

    // Fetch side.
    input  logic        inst_data_ok,
    input  logic        icache_stall,
    input  logic        inst_uncached,
    output logic        current_exception,
    output logic        flush,
    output logic [31:0] new_pc,
    output logic [4:0]  exc_code,

    // mfc0/mtc0.
    input  logic        cp0_we,
    input  logic [4:0]  cp0_addr,
    input  logic [31:0] cp0_wdata,
    output logic [31:0] cp0_rdata,

    input  logic [5:0]  hw_int
);

    logic        exc_we;
    logic [31:0] exc_epc;
    logic        exc_bd;
    logic        badvaddr_we;
    logic [31:0] badvaddr;
    logic        eret_commit;
    logic        int_pending;
    logic [31:0] epc_out;

    exception_unit i_exception_unit (
        .clk, .reset,
        .pc, .data_vaddr, .data_we, .in_delayslot,
        .illegal_inst, .illegal_data, .syscall, .brk, .trap, .unknown_inst, .overflow, .eret,
        .int_pending, .epc_out,
        .inst_data_ok, .icache_stall, .inst_uncached,
        .current_exception, .flush, .new_pc,
        .exc_we, .exc_code, .exc_epc, .exc_bd,
        .badvaddr_we, .badvaddr, .eret_commit
    );

    cp0_regs i_cp0_regs (
        .clk, .reset,
        .cp0_we, .cp0_addr, .cp0_wdata, .cp0_rdata,
        .hw_int,
        .exc_we, .exc_code, .exc_epc, .exc_bd,
        .badvaddr_we, .badvaddr, .eret_commit,
        .int_pending, .epc_out
    );

endmodule

//--- verification/exc_ref.svh
`ifndef EXC_REF_SVH
`define EXC_REF_SVH

// ==============================
// Reference model
// ==============================

// Which event a cause set resolves to, highest priority first.
typedef enum int {
    W_INT, W_IADE, W_DADE, W_SYS, W_BP, W_TR, W_RI, W_OV, W_ERET, W_NONE
} winner_t;

// Software IP bits stay zero since Cause is never written.
function automatic logic ref_int(input logic [31:0] status, input logic [5:0] hw);
    return status[STATUS_IE] && !status[STATUS_EXL]
        && |({hw, 2'b00} & status[STATUS_IM_LO +: 8]);
endfunction

// Cause bits: 0 inst AdEL, 1 data AdE, 2 sys, 3 bp, 4 tr, 5 ri, 6 ov, 7 eret.
function automatic winner_t ref_winner(input logic [7:0] causes, input logic int_req);
    if (int_req)   return W_INT;
    if (causes[0]) return W_IADE;
    if (causes[1]) return W_DADE;
    if (causes[2]) return W_SYS;
    if (causes[3]) return W_BP;
    if (causes[4]) return W_TR;
    if (causes[5]) return W_RI;
    if (causes[6]) return W_OV;
    if (causes[7]) return W_ERET;
    return W_NONE;
endfunction

function automatic logic [4:0] ref_code(input winner_t w, input logic dwe);
    case (w)
        W_INT:   return EXC_INT;
        W_IADE:  return EXC_ADEL;
        W_DADE:  return dwe ? EXC_ADES : EXC_ADEL;
        W_SYS:   return EXC_SYS;
        W_BP:    return EXC_BP;
        W_TR:    return EXC_TR;
        W_RI:    return EXC_RI;
        W_OV:    return EXC_OV;
        default: return 5'd0;  // eret and idle carry no code.
    endcase
endfunction

function automatic logic [31:0] ref_redirect(input winner_t w, input logic [31:0] epc,
                                             input logic [31:0] prev);
    if (w == W_NONE) return prev;  // Redirect target holds.
    if (w == W_ERET) return epc;
    return EXC_VECTOR;
endfunction

function automatic logic [31:0] ref_epc(input logic [31:0] pc_v, input logic ds);
    return ds ? pc_v - 32'd4 : pc_v;
endfunction

function automatic logic [31:0] ref_badvaddr(input winner_t w, input logic [31:0] pc_v,
                                             input logic [31:0] dv);
    return (w == W_IADE) ? pc_v : dv;
endfunction

function automatic logic [31:0] ref_cause(input logic [4:0] code, input logic bd);
    logic [31:0] word;
    word = 32'd0;
    word[CAUSE_BD] = bd;
    word[CAUSE_EXC_LO +: 5] = code;
    return word;
endfunction

`endif

//--- verification/exc_tb.sv
`timescale 1ns/1ps

module exc_tb;

    import exc_pkg::*;

    `include "exc_ref.svh"

    typedef struct packed {
        logic        cur;
        logic [4:0]  code;
        logic [31:0] npc;
        logic        fl;
    } exp_t;

    logic clk, reset;
    logic [31:0] pc, data_vaddr, cp0_wdata, cp0_rdata, new_pc;
    logic data_we, in_delayslot, illegal_inst, illegal_data, syscall, brk, trap;
    logic unknown_inst, overflow, eret, inst_data_ok, icache_stall, inst_uncached;
    logic current_exception, flush, cp0_we;
    logic [4:0] exc_code, cp0_addr;
    logic [5:0] hw_int;

    exp_t cause_q[$];
    exp_t out_q[$];
    exp_t cmp_item;
    string test_name;
    int n_tests, n_checks, n_errors, test_checks, test_errors;
    logic [31:0] sh_status, sh_epc, sh_new_pc;  // Shadow CP0 state.

    exc_top i_exc_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #2_000_000;
        $display("Simulation timed out before the test sequence ended.");
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        test_checks++;
        if (exp !== act) begin
            $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
            n_errors++;
            test_errors++;
        end
    endtask

    // ==============================
    // Compare process
    // ==============================
    always @(negedge clk) begin
        if (out_q.size() > 0) begin
            cmp_item = out_q.pop_front();
            check("exc_code", cmp_item.code, exc_code);
            check("new_pc", cmp_item.npc, new_pc);
            check("flush", cmp_item.fl, flush);
        end
        if (cause_q.size() > 0) begin
            cmp_item = cause_q.pop_front();
            check("current_exception", cmp_item.cur, current_exception);
            out_q.push_back(cmp_item);
        end
    end

    task automatic begin_test(input string name);
        test_name = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        n_tests++;
    endtask

    task automatic mtc0(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        cp0_we <= 1'b1;
        cp0_addr <= addr;
        cp0_wdata <= data;
        @(posedge clk);
        cp0_we <= 1'b0;
        if (addr == CP0_STATUS) sh_status = data & 32'h0000_FF03;  // IM, EXL, IE.
        if (addr == CP0_EPC) sh_epc = data;
    endtask

    task automatic read_check(input string what, input logic [4:0] addr, input logic [31:0] exp);
        @(posedge clk);
        cp0_addr <= addr;
        @(negedge clk);
        check(what, exp, cp0_rdata);
    endtask

    task automatic wait_flush_low(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (flush !== 1'b0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (flush !== 1'b0) begin
            $display("Timeout in %s: flush still high after %0d cycles.", test_name, limit);
            n_errors++;
            test_errors++;
        end
    endtask

    // One cause set for one cycle, then the expected response.
    task automatic run_case(input logic [7:0] causes, input logic [5:0] hw,
                            input logic [31:0] pc_v, input logic [31:0] dv, input logic dwe,
                            input logic ds, input bit readback, input bit wait_release);
        winner_t w;
        exp_t e;
        w = ref_winner(causes, ref_int(sh_status, hw));
        e.cur = (w != W_NONE);
        e.code = ref_code(w, dwe);
        e.npc = ref_redirect(w, sh_epc, sh_new_pc);
        e.fl = (w != W_NONE);
        @(posedge clk);
        {eret, overflow, unknown_inst, trap, brk, syscall, illegal_data, illegal_inst} <= causes;
        hw_int <= hw;
        pc <= pc_v;
        data_vaddr <= dv;
        data_we <= dwe;
        in_delayslot <= ds;
        cause_q.push_back(e);
        @(posedge clk);
        {eret, overflow, unknown_inst, trap, brk, syscall, illegal_data, illegal_inst} <= 8'd0;
        hw_int <= 6'd0;
        sh_new_pc = e.npc;
        if (w == W_ERET) begin
            sh_status[STATUS_EXL] = 1'b0;
        end else if (w != W_NONE) begin
            sh_status[STATUS_EXL] = 1'b1;
            sh_epc = ref_epc(pc_v, ds);
        end
        @(posedge clk);  // CP0 updated on this edge.
        if (wait_release) wait_flush_low(8);
        if (readback && w != W_NONE) begin
            read_check("status", CP0_STATUS, sh_status);
            read_check("epc", CP0_EPC, sh_epc);
            if (w != W_ERET) read_check("cause", CP0_CAUSE, ref_cause(e.code, ds));
            if (w == W_IADE || w == W_DADE) begin
                read_check("badvaddr", CP0_BADVADDR, ref_badvaddr(w, pc_v, dv));
            end
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        logic [31:0] rnd;
        logic [7:0] causes;
        int i;
        void'($urandom(32'hc1e8be82));
        {pc, data_vaddr, cp0_wdata} = '0;
        {data_we, in_delayslot, illegal_inst, illegal_data, syscall, brk, trap} = '0;
        {unknown_inst, overflow, eret, inst_data_ok, icache_stall, inst_uncached} = '0;
        cp0_we = 1'b0;
        cp0_addr = 5'd0;
        hw_int = 6'd0;
        sh_status = STATUS_RESET;
        sh_epc = 32'd0;
        sh_new_pc = 32'd0;
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        begin_test("reset_state");
        @(negedge clk);
        check("flush", 1'b0, flush);
        check("new_pc", 32'd0, new_pc);
        read_check("status", CP0_STATUS, STATUS_RESET);
        end_test();

        begin_test("priority");
        mtc0(CP0_EPC, 32'h8000_1000);  // Defined eret target.
        for (i = 0; i < 40; i++) begin
            rnd = $urandom;
            mtc0(CP0_STATUS, rnd[31] ? 32'h0000_FC01 : 32'h0000_0000);
            causes = rnd[7:0] & rnd[15:8];
            if (causes == 8'd0) causes = 8'h04;
            run_case(causes, rnd[21:16], $urandom, $urandom, rnd[22], rnd[23], 1'b0, 1'b1);
        end
        end_test();

        begin_test("recorded_state");
        for (i = 0; i < 24; i++) begin
            rnd = $urandom;
            causes = rnd[7:0] & rnd[15:8];
            if (causes == 8'd0) causes = 8'h01;
            run_case(causes, 6'd0, $urandom, $urandom, rnd[22], rnd[23], 1'b1, 1'b1);
        end
        end_test();

        begin_test("int_masking");
        mtc0(CP0_STATUS, 32'h0000_2001);  // IE and IM5, which is hw_int[3].
        run_case(8'd0, 6'b001000, 32'h8000_0100, 32'd0, 1'b0, 1'b0, 1'b1, 1'b1);
        run_case(8'd0, 6'b001000, 32'h8000_0104, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        mtc0(CP0_STATUS, 32'h0000_DC01);  // IM5 clear, IM6 set.
        run_case(8'd0, 6'b001000, 32'h8000_0108, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        run_case(8'd0, 6'b010000, 32'h8000_010c, 32'd0, 1'b0, 1'b0, 1'b1, 1'b1);
        end_test();

        begin_test("eret");
        mtc0(CP0_STATUS, 32'h0000_0000);
        run_case(8'h04, 6'd0, 32'h8000_2468, 32'd0, 1'b0, 1'b1, 1'b1, 1'b1);
        run_case(8'h80, 6'd0, 32'h8000_3000, 32'd0, 1'b0, 1'b0, 1'b1, 1'b1);
        mtc0(CP0_EPC, 32'h8000_0abc);
        run_case(8'h80, 6'd0, 32'h8000_3004, 32'd0, 1'b0, 1'b0, 1'b1, 1'b1);
        end_test();

        begin_test("flush_hold");
        @(posedge clk);
        icache_stall <= 1'b1;
        run_case(8'h04, 6'd0, 32'h8000_4000, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0);
        repeat (5) begin
            @(negedge clk);
            check("flush_held", 1'b1, flush);
        end
        @(posedge clk);
        inst_data_ok <= 1'b1;
        wait_flush_low(8);
        @(posedge clk);
        icache_stall <= 1'b0;
        inst_data_ok <= 1'b0;
        end_test();

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+verification
design/exc_pkg.sv
design/exception_unit.sv
design/cp0_regs.sv
design/exc_top.sv
verification/exc_tb.sv

//--- Bender.yml
package:
  name: exc_cp0

sources:
  - files:
      - design/exc_pkg.sv
      - design/exception_unit.sv
      - design/cp0_regs.sv
      - design/exc_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/exc_tb.sv
